// ==== src/life_pkg.sv ====
/* grid geometry and LFSR constants for the 16x16 toroidal automaton
   the LFSR is as wide as one row, so one state is one seed row */
package life_pkg;

	//////////////////////////////////////////////////////////////////////
	// grid geometry
	//////////////////////////////////////////////////////////////////////

	localparam int GRID_COLS = 16;
	localparam int GRID_ROWS = 16;

	// one row of cells, bit n is column n
	typedef logic [GRID_COLS-1:0] row_t;
	typedef logic [$clog2(GRID_ROWS)-1:0] row_addr_t;
	// msb selects the bank
	typedef logic [$clog2(GRID_ROWS):0] bank_addr_t;
	// completed generations, wraps
	typedef logic [15:0] gen_count_t;

	//////////////////////////////////////////////////////////////////////
	// seed generator
	//////////////////////////////////////////////////////////////////////

	// state after reset, must be nonzero
	localparam logic [15:0] LFSR_SEED = 16'hACE1;
	// xor mask applied when a one drops out of bit 0
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

endpackage

// ==== src/ctrl_pkg.sv ====
/* button filter timing in clk cycles, kept short for simulation
   and the state encodings of the debouncer and the sequencer */
package ctrl_pkg;

	//////////////////////////////////////////////////////////////////////
	// fire button timing
	//////////////////////////////////////////////////////////////////////

	// synchronized level must stay high this long to count
	localparam int DB_PRESS_CYCLES = 16;
	// from start of press to long-hold
	localparam int DB_LONG_CYCLES = 400;
	// low time before the filter goes back to idle
	localparam int DB_RELEASE_CYCLES = 32;

	//////////////////////////////////////////////////////////////////////
	// state machines
	//////////////////////////////////////////////////////////////////////

	// debouncer
	typedef enum logic [2:0] {
		db_idle,
		db_wait_press,
		db_pressed,
		db_wait_long,
		db_long_hold,
		db_wait_off,
		db_wait_long_off
	} db_state_t;

	// generation sequencer
	typedef enum logic [1:0] {
		seq_seeding,
		seq_idle,
		seq_running
	} seq_state_t;

endpackage

// ==== src/button_debounce.sv ====
/* fire_button is asynchronous; bounces shorter than the press filter give no output
   long_hold persists until the release filter runs out */
module button_debounce (
	input  logic clk,
	input  logic reset,
	input  logic fire_button,
	output logic press_pulse,
	output logic long_hold
);
	logic sync_meta;
	logic sync_in;
	ctrl_pkg::db_state_t state;
	// cycles since press start, saturates at the long threshold
	logic [$clog2(ctrl_pkg::DB_LONG_CYCLES + 1)-1:0] press_cnt;
	// cycles low while waiting for release
	logic [$clog2(ctrl_pkg::DB_RELEASE_CYCLES + 1)-1:0] rel_cnt;
	logic release_done;

	// two-flop synchronizer
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_meta <= 1'b0;
			sync_in <= 1'b0;
		end else begin
			sync_meta <= fire_button;
			sync_in <= sync_meta;
		end
	end

	assign release_done = (rel_cnt == ctrl_pkg::DB_RELEASE_CYCLES - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrl_pkg::db_idle;
			press_cnt <= '0;
			rel_cnt <= '0;
		end else begin
			// press timer runs from first high sample until idle
			if (state == ctrl_pkg::db_idle)
				press_cnt <= '0;
			else if (press_cnt != ctrl_pkg::DB_LONG_CYCLES)
				press_cnt <= press_cnt + 1'b1;
			// release timer only counts while low
			if (state == ctrl_pkg::db_wait_off || state == ctrl_pkg::db_wait_long_off)
				rel_cnt <= rel_cnt + 1'b1;
			else
				rel_cnt <= '0;

			case (state)
				ctrl_pkg::db_idle:
					if (sync_in)
						state <= ctrl_pkg::db_wait_press;
				ctrl_pkg::db_wait_press:
					if (!sync_in)
						state <= ctrl_pkg::db_idle;
					else if (press_cnt == ctrl_pkg::DB_PRESS_CYCLES - 1)
						state <= ctrl_pkg::db_pressed;
				// single cycle, this is the pulse
				ctrl_pkg::db_pressed:
					state <= ctrl_pkg::db_wait_long;
				ctrl_pkg::db_wait_long:
					if (!sync_in)
						state <= ctrl_pkg::db_wait_off;
					else if (press_cnt >= ctrl_pkg::DB_LONG_CYCLES - 1)
						state <= ctrl_pkg::db_long_hold;
				ctrl_pkg::db_long_hold:
					if (!sync_in)
						state <= ctrl_pkg::db_wait_long_off;
				// high again during release counts as the same press
				ctrl_pkg::db_wait_off:
					if (sync_in)
						state <= ctrl_pkg::db_wait_long;
					else if (release_done)
						state <= ctrl_pkg::db_idle;
				ctrl_pkg::db_wait_long_off:
					if (sync_in)
						state <= ctrl_pkg::db_long_hold;
					else if (release_done)
						state <= ctrl_pkg::db_idle;
				default:
					state <= ctrl_pkg::db_idle;
			endcase
		end
	end

	assign press_pulse = (state == ctrl_pkg::db_pressed);
	assign long_hold = (state == ctrl_pkg::db_long_hold) || (state == ctrl_pkg::db_wait_long_off);

endmodule

// ==== src/seed_lfsr.sv ====
/* Galois LFSR, one row per seed_step, restarts from LFSR_SEED on reset */
module seed_lfsr (
	input  logic           clk,
	input  logic           reset,
	input  logic           seed_step,
	output life_pkg::row_t seed_row
);
	life_pkg::row_t lfsr;

	always_ff @(posedge clk) begin
		if (reset) begin
			lfsr <= life_pkg::LFSR_SEED;
		end else if (seed_step) begin
			// shift right, fold taps in when a one falls out
			if (lfsr[0])
				lfsr <= (lfsr >> 1) ^ life_pkg::LFSR_TAPS;
			else
				lfsr <= lfsr >> 1;
		end
	end

	// current state is the row being written
	assign seed_row = lfsr;

endmodule

// ==== src/life_engine.sv ====
/* read data is valid one cycle after rd_addr; a next row is valid for writing
   two cycles after the shift that completes its window */
module life_engine (
	input  logic                 clk,
	input  life_pkg::bank_addr_t rd_addr,
	input  life_pkg::bank_addr_t wr_addr,
	input  logic                 wr_en,
	input  logic                 wr_seed,
	input  life_pkg::row_t       seed_row,
	input  logic                 shift_en,
	input  logic                 load_out,
	output life_pkg::row_t       row_data
);
	// both banks in one array, bank bit is the address msb
	life_pkg::row_t mem [2 * life_pkg::GRID_ROWS];
	life_pkg::row_t rd_data;
	// three-row window, index 0 is the newest row
	life_pkg::row_t [2:0] window;
	logic [1:0] col_sum [life_pkg::GRID_COLS];
	logic [1:0] col_sum_q [life_pkg::GRID_COLS];
	life_pkg::row_t mid_q;
	logic [3:0] box_sum [life_pkg::GRID_COLS];
	life_pkg::row_t next_row;
	logic load_d;

	//////////////////////////////////////////////////////////////////////
	// cell RAM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
		if (wr_en)
			mem[wr_addr] <= wr_seed ? seed_row : next_row;
	end

	// external row read, capture the cycle the data comes out
	always_ff @(posedge clk) begin
		load_d <= load_out;
		if (load_d)
			row_data <= rd_data;
	end

	//////////////////////////////////////////////////////////////////////
	// row window and rule
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (shift_en)
			window <= {window[1:0], rd_data};
	end

	// vertical sums per column, center row included
	always_comb begin
		for (int c = 0; c < life_pkg::GRID_COLS; c++) begin
			col_sum[c] = {1'b0, window[0][c]} + {1'b0, window[1][c]} + {1'b0, window[2][c]};
		end
	end

	// free running stage, follows the window one cycle later
	always_ff @(posedge clk) begin
		col_sum_q <= col_sum;
		mid_q <= window[1];
	end

	// 3x3 box with wrap at both edges, still includes the cell itself
	always_comb begin
		for (int c = 0; c < life_pkg::GRID_COLS; c++) begin
			box_sum[c] = {2'b00, col_sum_q[(c + 1) % life_pkg::GRID_COLS]}
				+ {2'b00, col_sum_q[c]}
				+ {2'b00, col_sum_q[(c + life_pkg::GRID_COLS - 1) % life_pkg::GRID_COLS]};
		end
	end

	// box of 3 means birth or survival with two, box of 4 only survival with three
	always_comb begin
		for (int c = 0; c < life_pkg::GRID_COLS; c++) begin
			next_row[c] = (box_sum[c] == 4'd3) || (mid_q[c] && box_sum[c] == 4'd4);
		end
	end

endmodule

// ==== src/generation_sequencer.sv ====
/* row requests are ignored until seeded and pause the row walk for their cycle;
   a press arriving while a generation runs is dropped */
module generation_sequencer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 press_pulse,
	input  logic                 long_hold,
	input  logic                 row_req,
	input  life_pkg::row_addr_t  row_addr,
	output logic                 seed_step,
	output life_pkg::bank_addr_t rd_addr,
	output life_pkg::bank_addr_t wr_addr,
	output logic                 wr_en,
	output logic                 wr_seed,
	output logic                 shift_en,
	output logic                 load_out,
	output logic                 row_valid,
	output life_pkg::gen_count_t gen_count,
	output logic                 seeded,
	output logic                 busy
);
	ctrl_pkg::seq_state_t state;
	life_pkg::row_addr_t seed_idx;
	// read walk covers GRID_ROWS + 2 rows, wrap row on each side
	logic [$clog2(life_pkg::GRID_ROWS + 3)-1:0] walk_cnt;
	logic [$clog2(life_pkg::GRID_ROWS + 3)-1:0] shift_cnt;
	logic bank;
	logic rd_issue;
	logic wr_pend;
	life_pkg::row_addr_t wr_row;
	logic req_d;
	logic req_ok;
	logic walk_go;
	logic start;
	logic gen_done;

	assign req_ok = row_req && seeded;
	assign walk_go = (state == ctrl_pkg::seq_running) && !req_ok
		&& (walk_cnt < life_pkg::GRID_ROWS + 2);
	assign start = (state == ctrl_pkg::seq_idle) && seeded && (press_pulse || long_hold);
	// last row of the new generation goes in this cycle
	assign gen_done = wr_en && !wr_seed
		&& (wr_addr[$bits(life_pkg::row_addr_t)-1:0] == life_pkg::row_addr_t'(life_pkg::GRID_ROWS - 1));
	// lfsr steps on the same edge its row is written
	assign seed_step = wr_seed;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrl_pkg::seq_seeding;
			seed_idx <= '0;
			walk_cnt <= '0;
			shift_cnt <= '0;
			bank <= 1'b0;
			rd_issue <= 1'b0;
			shift_en <= 1'b0;
			wr_pend <= 1'b0;
			wr_en <= 1'b0;
			wr_seed <= 1'b0;
			load_out <= 1'b0;
			req_d <= 1'b0;
			row_valid <= 1'b0;
			gen_count <= '0;
			seeded <= 1'b0;
			busy <= 1'b0;
		end else begin
			// read side, data is in the window one cycle after the address
			rd_issue <= walk_go;
			shift_en <= rd_issue;
			// row_valid three stages behind the request
			load_out <= req_ok;
			req_d <= load_out;
			row_valid <= req_d;
			// third shift onward completes a window
			wr_pend <= shift_en && (shift_cnt >= 2);
			wr_seed <= (state == ctrl_pkg::seq_seeding);
			wr_en <= (state == ctrl_pkg::seq_seeding) || wr_pend;
			if (shift_en)
				shift_cnt <= shift_cnt + 1'b1;
			if (walk_go)
				walk_cnt <= walk_cnt + 1'b1;

			case (state)
				ctrl_pkg::seq_seeding: begin
					seed_idx <= seed_idx + 1'b1;
					if (seed_idx == life_pkg::row_addr_t'(life_pkg::GRID_ROWS - 1))
						state <= ctrl_pkg::seq_idle;
				end
				ctrl_pkg::seq_idle: begin
					// last seed row is in the RAM by now
					seeded <= 1'b1;
					if (start) begin
						state <= ctrl_pkg::seq_running;
						busy <= 1'b1;
						walk_cnt <= '0;
						shift_cnt <= '0;
					end
				end
				ctrl_pkg::seq_running:
					if (gen_done) begin
						bank <= ~bank;
						gen_count <= gen_count + 1'b1;
						busy <= 1'b0;
						state <= ctrl_pkg::seq_idle;
					end
				default:
					state <= ctrl_pkg::seq_idle;
			endcase
		end
	end

	// addresses, walk row is walk_cnt - 1 so the walk starts on the last row
	always_ff @(posedge clk) begin
		wr_row <= life_pkg::row_addr_t'(shift_cnt - 2'd2);
		if (req_ok)
			rd_addr <= {bank, row_addr};
		else
			rd_addr <= {bank, life_pkg::row_addr_t'(walk_cnt - 1'b1)};
		if (state == ctrl_pkg::seq_seeding)
			wr_addr <= {1'b0, seed_idx};
		else
			wr_addr <= {~bank, wr_row};
	end

endmodule

// ==== src/life_top.sv ====
/* single clock domain; row_valid follows row_req by three cycles
   and row_req is ignored until seeded */
module life_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 fire_button,
	input  logic                 row_req,
	input  life_pkg::row_addr_t  row_addr,
	output logic                 row_valid,
	output life_pkg::row_t       row_data,
	output life_pkg::gen_count_t gen_count,
	output logic                 seeded,
	output logic                 busy
);
	logic press_pulse;
	logic long_hold;
	logic seed_step;
	life_pkg::row_t seed_row;
	life_pkg::bank_addr_t rd_addr;
	life_pkg::bank_addr_t wr_addr;
	logic wr_en;
	logic wr_seed;
	logic shift_en;
	logic load_out;

	// button filter
	button_debounce button_debounce_i (
		.clk         (clk),
		.reset       (reset),
		.fire_button (fire_button),
		.press_pulse (press_pulse),
		.long_hold   (long_hold)
	);

	// initial grid source
	seed_lfsr seed_lfsr_i (
		.clk       (clk),
		.reset     (reset),
		.seed_step (seed_step),
		.seed_row  (seed_row)
	);

	// control
	generation_sequencer generation_sequencer_i (
		.clk         (clk),
		.reset       (reset),
		.press_pulse (press_pulse),
		.long_hold   (long_hold),
		.row_req     (row_req),
		.row_addr    (row_addr),
		.seed_step   (seed_step),
		.rd_addr     (rd_addr),
		.wr_addr     (wr_addr),
		.wr_en       (wr_en),
		.wr_seed     (wr_seed),
		.shift_en    (shift_en),
		.load_out    (load_out),
		.row_valid   (row_valid),
		.gen_count   (gen_count),
		.seeded      (seeded),
		.busy        (busy)
	);

	// datapath
	life_engine life_engine_i (
		.clk      (clk),
		.rd_addr  (rd_addr),
		.wr_addr  (wr_addr),
		.wr_en    (wr_en),
		.wr_seed  (wr_seed),
		.seed_row (seed_row),
		.shift_en (shift_en),
		.load_out (load_out),
		.row_data (row_data)
	);

endmodule

// ==== tests/life_tb_checks.svh ====
/* compare tasks and the row-read helper, included inside life_tb
   read_grid expects the sequencer idle so all rows come from one generation */
`ifndef LIFE_TB_CHECKS_SVH
`define LIFE_TB_CHECKS_SVH

	task automatic check_row(input life_pkg::row_t got, input life_pkg::row_t exp,
			input string what);
		checks++;
		if (got !== exp) begin
			$display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input life_pkg::gen_count_t got,
			input life_pkg::gen_count_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("mismatch at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// one request per cycle, then collect until every row is back
	task automatic read_grid(input string what);
		int waited;
		resp_q.delete();
		for (int r = 0; r < life_pkg::GRID_ROWS; r++)
			drive_cycle(1'b0, 1'b1, life_pkg::row_addr_t'(r));
		waited = 0;
		while (resp_q.size() < life_pkg::GRID_ROWS && waited < 8) begin
			drive_cycle(1'b0, 1'b0, '0);
			waited++;
		end
		if (resp_q.size() != life_pkg::GRID_ROWS) begin
			$display("%s: only %0d of %0d rows came back at %0d ns",
				what, resp_q.size(), life_pkg::GRID_ROWS, $time);
			errors++;
		end else begin
			for (int r = 0; r < life_pkg::GRID_ROWS; r++)
				check_row(resp_q[r], model[r], $sformatf("%s row %0d", what, r));
		end
	endtask

`endif

// ==== tests/life_tb.sv ====
/* directed tests of life_top against a software torus model; a press during
   the debounce release window is part of the previous press, so tests settle first */
module life_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// twice the sum of all tests, mostly the two long holds
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int LONG_PRESS = 3000;
	localparam int SHORT_PRESS = 4 * ctrl_pkg::DB_PRESS_CYCLES;
	localparam int BOUNCES = 8;

	logic clk = 1'b0;
	logic reset;
	logic fire_button;
	logic row_req;
	life_pkg::row_addr_t row_addr;
	logic row_valid;
	life_pkg::row_t row_data;
	life_pkg::gen_count_t gen_count;
	logic seeded;
	logic busy;

	// expected grid of the current generation
	life_pkg::row_t model [life_pkg::GRID_ROWS];
	// generation count the model has reached
	life_pkg::gen_count_t exp_gen;
	// row_data of every row_valid in arrival order
	life_pkg::row_t resp_q [$];
	logic busy_seen;
	logic [31:0] rng_state = 32'h9c10272c;
	int cycle_count = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;

	life_top life_top_i (
		.clk         (clk),
		.reset       (reset),
		.fire_button (fire_button),
		.row_req     (row_req),
		.row_addr    (row_addr),
		.row_valid   (row_valid),
		.row_data    (row_data),
		.gen_count   (gen_count),
		.seeded      (seeded),
		.busy        (busy)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// hard stop
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reference models
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// shift right and xor the taps in when a one drops out
	function automatic life_pkg::row_t lfsr_next(input life_pkg::row_t s);
		life_pkg::row_t t;
		t = s >> 1;
		if (s[0])
			t = t ^ life_pkg::LFSR_TAPS;
		return t;
	endfunction

	// one torus generation with the eight neighbors counted directly
	task automatic step_model();
		life_pkg::row_t nxt [life_pkg::GRID_ROWS];
		int n;
		for (int r = 0; r < life_pkg::GRID_ROWS; r++) begin
			for (int c = 0; c < life_pkg::GRID_COLS; c++) begin
				n = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						if (dr != 0 || dc != 0)
							n += model[(r + dr + life_pkg::GRID_ROWS) % life_pkg::GRID_ROWS]
								[(c + dc + life_pkg::GRID_COLS) % life_pkg::GRID_COLS];
					end
				end
				nxt[r][c] = (n == 3) || (model[r][c] && n == 2);
			end
		end
		model = nxt;
	endtask

	//////////////////////////////////////////////////////////////////////
	// cycle helpers
	//////////////////////////////////////////////////////////////////////

	// drive on the rising edge and sample on the falling edge
	task automatic drive_cycle(input logic button, input logic req,
			input life_pkg::row_addr_t addr);
		@(posedge clk);
		fire_button <= button;
		row_req <= req;
		row_addr <= addr;
		@(negedge clk);
		if (row_valid)
			resp_q.push_back(row_data);
		if (busy)
			busy_seen = 1'b1;
	endtask

	// button low until busy has stayed low longer than the release filter
	task automatic wait_idle(input int limit);
		int quiet;
		int waited;
		quiet = 0;
		waited = 0;
		while (quiet < ctrl_pkg::DB_RELEASE_CYCLES + 8 && waited < limit) begin
			drive_cycle(1'b0, 1'b0, '0);
			quiet = busy ? 0 : quiet + 1;
			waited++;
		end
		if (quiet < ctrl_pkg::DB_RELEASE_CYCLES + 8) begin
			$display("busy did not settle low within %0d cycles at %0d ns", limit, $time);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

`include "life_tb_checks.svh"

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic seeding_readback();
		int err0;
		int waited;
		err0 = errors;
		resp_q.delete();
		// requests in the first half of seeding get no answer
		for (int i = 0; i < life_pkg::GRID_ROWS / 2; i++)
			drive_cycle(1'b0, 1'b1, life_pkg::row_addr_t'(i));
		check_flag(seeded, 1'b0, "seeded while seed rows are written");
		waited = 0;
		while (!seeded && waited < 100) begin
			drive_cycle(1'b0, 1'b0, '0);
			waited++;
		end
		check_flag(seeded, 1'b1, "seeded after reset");
		check_flag(resp_q.size() == 0, 1'b1,
			$sformatf("%0d row_valid before seeded", resp_q.size()));
		exp_gen = '0;
		check_count(gen_count, exp_gen, "gen_count after seeding");
		// rows 0 up hold successive lfsr states
		model[0] = life_pkg::LFSR_SEED;
		for (int r = 1; r < life_pkg::GRID_ROWS; r++)
			model[r] = lfsr_next(model[r - 1]);
		read_grid("seed grid");
		finish_test("seeding", err0);
	endtask

	task automatic single_press_step();
		int err0;
		err0 = errors;
		busy_seen = 1'b0;
		// past the press filter but well short of long hold
		repeat (SHORT_PRESS)
			drive_cycle(1'b1, 1'b0, '0);
		wait_idle(200);
		check_flag(busy_seen, 1'b1, "busy during single step");
		exp_gen = exp_gen + 1'b1;
		check_count(gen_count, exp_gen, "gen_count after one press");
		step_model();
		read_grid("single step grid");
		finish_test("single step", err0);
	endtask

	task automatic bounce_rejection();
		int err0;
		int len;
		int gap;
		err0 = errors;
		busy_seen = 1'b0;
		for (int i = 0; i < BOUNCES; i++) begin
			len = 1 + next_random() % (ctrl_pkg::DB_PRESS_CYCLES - 2);
			gap = ctrl_pkg::DB_RELEASE_CYCLES + next_random() % 16;
			repeat (len)
				drive_cycle(1'b1, 1'b0, '0);
			repeat (gap)
				drive_cycle(1'b0, 1'b0, '0);
		end
		check_flag(busy_seen, 1'b0, "no generation from bounces");
		check_count(gen_count, exp_gen, "gen_count after bounces");
		read_grid("grid after bounces");
		finish_test("bounce rejection", err0);
	endtask

	// long hold with optional random row reads while generations run
	task automatic long_hold_run(input string name, input logic with_reads);
		int err0;
		int reqs;
		logic req;
		logic [31:0] r;
		life_pkg::gen_count_t steps;
		err0 = errors;
		resp_q.delete();
		reqs = 0;
		for (int i = 0; i < LONG_PRESS; i++) begin
			r = next_random();
			// about one cycle in four
			req = with_reads && (r[1:0] == 2'b00);
			if (req)
				reqs++;
			drive_cycle(1'b1, req, r[11:8]);
		end
		wait_idle(400);
		steps = gen_count - exp_gen;
		check_flag(steps > 2, 1'b1, $sformatf("%0d generations from a long hold", steps));
		if (with_reads)
			check_flag(resp_q.size() == reqs, 1'b1,
				$sformatf("%0d row_valid for %0d requests", resp_q.size(), reqs));
		repeat (steps)
			step_model();
		exp_gen = exp_gen + steps;
		read_grid({name, " grid"});
		finish_test(name, err0);
	endtask

	initial begin
		reset = 1'b1;
		fire_button = 1'b0;
		row_req = 1'b0;
		row_addr = '0;
		busy_seen = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		seeding_readback();
		single_press_step();
		bounce_rejection();
		long_hold_run("long hold", 1'b0);
		long_hold_run("reads during generations", 1'b1);

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+tests
src/life_pkg.sv
src/ctrl_pkg.sv
src/button_debounce.sv
src/seed_lfsr.sv
src/life_engine.sv
src/generation_sequencer.sv
src/life_top.sv
tests/life_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -Wno-fatal -f files.f --top-module life_tb -o life_sim \
	> build.log 2>&1 && ./obj_dir/life_sim > sim.log 2>&1 || { cat build.log; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
